/* prach_top.f */
src/prach_pkg.sv
src/prach_gain_stage.sv
src/prach_sample_fifo.sv
src/prach_oran_packer.sv
src/prach_top.sv
tb/prach_top_sva.sv
tb/prach_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the prach testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module prach_top_tb \
   -f prach_top.f \
   -o prach_top_sim

sim_out=$(./obj_dir/prach_top_sim) || true
echo "$sim_out"

if grep -qF -- '** PASS **' <<< "$sim_out"; then
   exit 0
else
   exit 1
fi

/* tb/prach_top_tb.sv */
`timescale 1ns/1ps

module prach_top_tb;

   localparam int n_car      = prach_pkg::n_carriers;
   localparam int max_cycles = 4000;   // twice the summed test lengths
   localparam prach_pkg::prach_gain_cfg_t unity_cfg = '{sign: 1'b0, scaler: 4'd1,
                                                       fraction: 16'd32768};

   logic                                    clk_1x;
   logic                                    resetn_1x;
   prach_pkg::prach_sample_t [n_car-1:0]    prach_in;
   logic [n_car-1:0]                        prach_in_valid;
   logic [n_car-1:0]                        clk_x1en;
   logic [n_car-1:0]                        prach_en_cfg;
   logic [n_car-1:0]                        ul_stream_en;
   prach_pkg::prach_gain_cfg_t [n_car-1:0]  gain_cfg;
   logic                                    swap_iq;
   logic                                    clear;
   prach_pkg::prach_oran_t                  oran_out;
   logic                                    oran_valid;
   logic                                    oran_ready;
   prach_pkg::prach_err_t                   err;

   prach_pkg::prach_sample_t  exp_q [n_car][$];   // model output per carrier
   int                        car_order [$];      // carrier of each coming packet
   int                        beat_idx;
   int                        pkt_car;
   int                        stall_cnt;          // valid without ready seen here
   int                        cycle_cnt;
   logic [15:0]               lfsr_state = 16'd7;

   prach_top prach_top_inst (
      .clk_1x(clk_1x), .resetn_1x(resetn_1x), .prach_in(prach_in),
      .prach_in_valid(prach_in_valid), .clk_x1en(clk_x1en), .prach_en_cfg(prach_en_cfg),
      .ul_stream_en(ul_stream_en), .gain_cfg(gain_cfg), .swap_iq(swap_iq), .clear(clear),
      .oran_out(oran_out), .oran_valid(oran_valid), .oran_ready(oran_ready), .err(err)
   );

   initial begin
      clk_1x = 1'b0;
      forever #50 clk_1x = ~clk_1x;   // 100 ns period
   end

   // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
   function automatic logic lfsr_step();
      logic fb;
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++)
         v = {v[30:0], lfsr_step()};
      return v;
   endfunction

   function automatic prach_pkg::prach_sample_t make_sample(
      input logic signed [15:0] i, input logic signed [15:0] q, input logic [1:0] uid);
      prach_pkg::prach_sample_t s;
      s.iq.i   = i;
      s.iq.q   = q;
      s.usr_id = uid;
      return s;
   endfunction

   function automatic prach_pkg::prach_sample_t rand_sample();
      logic [31:0] ri;
      logic [31:0] rq;
      logic [31:0] ru;
      ri = rand_bits(16);
      rq = rand_bits(16);
      ru = rand_bits(2);
      return make_sample(ri[15:0], rq[15:0], ru[1:0]);
   endfunction

   // x * fraction, shift by 16 - scaler, negate on sign, clamp to 16 bits
   function automatic logic signed [15:0] scale_value(input logic signed [15:0] x,
                                                      input prach_pkg::prach_gain_cfg_t g);
      longint p;
      p = longint'(x) * longint'(g.fraction);
      p = p >>> (16 - int'(g.scaler));
      if (g.sign)
         p = -p;
      if (p > 32767)
         p = 32767;
      else if (p < -32768)
         p = -32768;
      return p[15:0];
   endfunction

   function automatic prach_pkg::prach_sample_t gain_model(input prach_pkg::prach_sample_t s,
                                                           input prach_pkg::prach_gain_cfg_t g);
      return make_sample(scale_value(s.iq.i, g), scale_value(s.iq.q, g), s.usr_id);
   endfunction

   function automatic prach_pkg::prach_err_t err_expect(input int stalls, input int ovfls);
      prach_pkg::prach_err_t e;
      int                    cap;
      cap          = (1 << prach_pkg::cnt_bw) - 1;   // counters stick at all ones
      e.vld_wo_rdy = (stalls > cap) ? cap[7:0] : stalls[7:0];
      e.fifo_ovfl  = (ovfls > cap) ? cap[7:0] : ovfls[7:0];
      return e;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "run stopped");
   endtask

   task automatic report_fail(input string msg);
      abort_run($sformatf("[FAIL] %0t ns %s", $time, msg));
   endtask

   task automatic check_beat(input prach_pkg::prach_oran_t got,
                             input prach_pkg::prach_oran_t exp);
      if (got !== exp)
         report_fail($sformatf("oran beat got %h/%h/%b expected %h/%h/%b", got.tdata,
                               got.tuser, got.tlast, exp.tdata, exp.tuser, exp.tlast));
   endtask

   task automatic check_err(input prach_pkg::prach_err_t got, input prach_pkg::prach_err_t exp);
      if (got !== exp)
         report_fail($sformatf("err counters got %0d/%0d expected %0d/%0d", got.vld_wo_rdy,
                               got.fifo_ovfl, exp.vld_wo_rdy, exp.fifo_ovfl));
   endtask

   task automatic next_cycle();
      @(posedge clk_1x);
      #10;   // inputs move just after the edge
   endtask

   task automatic apply_reset();
      resetn_1x      = 1'b0;
      prach_in_valid = '0;
      repeat (4) @(posedge clk_1x);
      #10;
      resetn_1x = 1'b1;
      foreach (exp_q[c]) exp_q[c].delete();
      car_order.delete();
      beat_idx  = 0;
      stall_cnt = 0;
   endtask

   task automatic load_sample(input int c, input prach_pkg::prach_sample_t s);
      prach_in[c]       = s;
      prach_in_valid[c] = 1'b1;
      if (clk_x1en[c] && prach_en_cfg[c] && ul_stream_en[c])   // every qualifier needed
         exp_q[c].push_back(gain_model(s, gain_cfg[c]));
   endtask

   task automatic send_samples(input int c, input int n);
      for (int k = 0; k < n; k++) begin
         load_sample(c, rand_sample());
         next_cycle();
      end
      prach_in_valid[c] = 1'b0;
   endtask

   task automatic expect_packets(input int c, input int n);
      repeat (n) car_order.push_back(c);
   endtask

   // all predicted beats out and the stream idle
   task automatic wait_drain();
      int left;
      do begin
         next_cycle();
         left = car_order.size();
         foreach (exp_q[c]) left += exp_q[c].size();
      end while (left != 0 || oran_valid);
   endtask

   task automatic test_unity();
      gain_cfg[0] = unity_cfg;
      expect_packets(0, 4);
      send_samples(0, 16);
      wait_drain();
   endtask

   task automatic test_gain();
      prach_pkg::prach_gain_cfg_t cfgs [4];
      cfgs[0] = '{sign: 1'b0, scaler: 4'd1, fraction: 16'd65535};    // just under two
      cfgs[1] = '{sign: 1'b1, scaler: 4'd1, fraction: 16'd32768};    // unity, negated
      cfgs[2] = '{sign: 1'b0, scaler: 4'd15, fraction: 16'd40000};   // shift of one
      cfgs[3] = '{sign: 1'b1, scaler: 4'd4, fraction: 16'd12345};
      foreach (cfgs[k]) begin
         gain_cfg[0] = cfgs[k];
         expect_packets(0, 2);
         load_sample(0, make_sample(-16'sd32768, 16'sd32767, 2'd1));
         next_cycle();
         load_sample(0, make_sample(16'sd32767, -16'sd32768, 2'd2));
         next_cycle();
         load_sample(0, make_sample(-16'sd1, 16'sd1, 2'd3));
         next_cycle();
         load_sample(0, make_sample(16'sd0, -16'sd32767, 2'd0));
         next_cycle();
         send_samples(0, 4);
         wait_drain();
      end
   endtask

   task automatic test_gating_swap();
      gain_cfg[0] = unity_cfg;
      swap_iq     = 1'b1;
      expect_packets(0, 2);   // 8 of 16 get through
      for (int k = 0; k < 16; k++) begin
         clk_x1en[0]     = (k % 6 != 1);
         prach_en_cfg[0] = (k % 6 != 3);
         ul_stream_en[0] = (k % 6 != 5);
         load_sample(0, rand_sample());
         next_cycle();
      end
      prach_in_valid = '0;
      clk_x1en       = '1;
      prach_en_cfg   = '1;
      ul_stream_en   = '1;
      wait_drain();
      swap_iq = 1'b0;
   endtask

   task automatic test_round_robin();
      apply_reset();   // round robin restarts at carrier 0
      gain_cfg[0] = unity_cfg;
      gain_cfg[1] = '{sign: 1'b0, scaler: 4'd2, fraction: 16'd50000};
      oran_ready  = 1'b0;
      car_order   = '{0, 1, 0, 1};
      for (int k = 0; k < 8; k++) begin
         load_sample(0, rand_sample());
         load_sample(1, rand_sample());
         next_cycle();
      end
      prach_in_valid = '0;
      while (!oran_valid) next_cycle();
      oran_ready = 1'b1;
      wait_drain();
   endtask

   task automatic test_backpressure();
      int lost;
      lost = 20 - prach_pkg::fifo_depth;
      apply_reset();
      gain_cfg[0] = unity_cfg;
      oran_ready  = 1'b0;
      expect_packets(0, prach_pkg::fifo_depth / prach_pkg::pkt_len);
      send_samples(0, 20);
      repeat (lost) void'(exp_q[0].pop_back());   // newest ones hit a full fifo
      repeat (4) next_cycle();                    // gain pipe plus ovfl register
      check_err(err, err_expect(stall_cnt, lost));
      oran_ready = 1'b1;
      wait_drain();
      check_err(err, err_expect(stall_cnt, lost));
      clear = 1'b1;
      next_cycle();
      clear     = 1'b0;
      stall_cnt = 0;
      check_err(err, err_expect(0, 0));
   endtask

   // beat checker, mid cycle so every signal has settled
   always @(negedge clk_1x) begin : monitor
      prach_pkg::prach_sample_t smp;
      prach_pkg::prach_oran_t   exp_beat;
      if (resetn_1x && oran_valid && !oran_ready) begin
         stall_cnt++;
      end else if (resetn_1x && oran_valid) begin
         if (beat_idx == 0 && car_order.size() == 0)
            abort_run("a packet came out while none was expected");
         else if (beat_idx == 0)
            pkt_car = car_order.pop_front();
         if (exp_q[pkt_car].size() == 0)
            abort_run($sformatf("carrier %0d sent more beats than it was given", pkt_car));
         smp            = exp_q[pkt_car].pop_front();
         exp_beat.tdata = swap_iq ? {smp.iq.i, smp.iq.q} : {smp.iq.q, smp.iq.i};
         exp_beat.tuser = {pkt_car[prach_pkg::car_bw-1:0], smp.usr_id};
         exp_beat.tlast = (beat_idx == prach_pkg::pkt_len - 1);
         check_beat(oran_out, exp_beat);
         beat_idx = (beat_idx + 1) % prach_pkg::pkt_len;
      end
   end

   always @(negedge clk_1x) begin
      cycle_cnt++;
      if (cycle_cnt > max_cycles)
         abort_run($sformatf("timeout, the tests did not finish in %0d cycles", max_cycles));
      else if (prach_top_inst.u_packer.sva_inst.fail_cnt != 0)
         abort_run("an assertion on the oran output stream failed");
   end

   initial begin
      resetn_1x      = 1'b0;
      prach_in       = '0;
      prach_in_valid = '0;
      clk_x1en       = '1;
      prach_en_cfg   = '1;
      ul_stream_en   = '1;
      gain_cfg       = {n_car{unity_cfg}};
      swap_iq        = 1'b0;
      clear          = 1'b0;
      oran_ready     = 1'b1;
      apply_reset();
      test_unity();
      test_gain();
      test_gating_swap();
      test_round_robin();
      test_backpressure();
      next_cycle();
      if (prach_top_inst.u_packer.sva_inst.fail_cnt == 0) begin
         $display("** PASS **");
         $finish;
      end else begin
         abort_run("an assertion on the oran output stream failed");
      end
   end

endmodule

/* tb/prach_top_sva.sv */
`timescale 1ns/1ps

module prach_top_sva (
   input  logic                     clk_1x,
   input  logic                     resetn_1x,
   input  logic                     oran_valid,
   input  logic                     oran_ready,
   input  prach_pkg::prach_oran_t   oran_out
);

   logic [prach_pkg::beat_bw-1:0]  beats;          // transfers since the last tlast
   int                             fail_cnt = 0;   // read by the testbench at the end

   always_ff @(posedge clk_1x) begin
      if (!resetn_1x)
         beats <= '0;
      else if (oran_valid && oran_ready)
         beats <= (beats == prach_pkg::last_beat) ? '0 : beats + 1'b1;
   end

   // a stalled beat stays put, word and valid
   hold_while_stalled: assert property (@(posedge clk_1x) disable iff (!resetn_1x)
      oran_valid && !oran_ready |=> oran_valid && $stable(oran_out))
      else begin fail_cnt++; $error("oran beat moved while stalled"); end

   // tlast exactly on every pkt_len-th transfer
   tlast_spacing: assert property (@(posedge clk_1x) disable iff (!resetn_1x)
      oran_valid && oran_ready |-> oran_out.tlast == (beats == prach_pkg::last_beat))
      else begin fail_cnt++; $error("tlast out of place in the packet"); end

   valid_low_in_reset: assert property (@(posedge clk_1x) !resetn_1x |=> !oran_valid)
      else begin fail_cnt++; $error("oran_valid high after a reset cycle"); end

endmodule

bind prach_oran_packer prach_top_sva sva_inst (
   .clk_1x     (clk_1x),
   .resetn_1x  (resetn_1x),
   .oran_valid (oran_valid),
   .oran_ready (oran_ready),
   .oran_out   (oran_out)
);

/* src/prach_top.sv */
`timescale 1ns/1ps

module prach_top (
   input  logic                                                      clk_1x,
   input  logic                                                      resetn_1x,
   input  prach_pkg::prach_sample_t [prach_pkg::n_carriers-1:0]      prach_in,
   input  logic [prach_pkg::n_carriers-1:0]                          prach_in_valid,
   input  logic [prach_pkg::n_carriers-1:0]                          clk_x1en,
   input  logic [prach_pkg::n_carriers-1:0]                          prach_en_cfg,
   input  logic [prach_pkg::n_carriers-1:0]                          ul_stream_en,
   input  prach_pkg::prach_gain_cfg_t [prach_pkg::n_carriers-1:0]    gain_cfg,
   input  logic                                                      swap_iq,
   input  logic                                                      clear,      // counter clear pulse
   output prach_pkg::prach_oran_t                                    oran_out,
   output logic                                                      oran_valid,
   input  logic                                                      oran_ready,
   output prach_pkg::prach_err_t                                     err
);

   logic [prach_pkg::n_carriers-1:0]                          carrier_en;
   logic [prach_pkg::n_carriers-1:0]                          fifo_wr;
   prach_pkg::prach_sample_t [prach_pkg::n_carriers-1:0]      fifo_din;
   prach_pkg::prach_sample_t [prach_pkg::n_carriers-1:0]      fifo_head;
   logic [prach_pkg::n_carriers-1:0][prach_pkg::lvl_bw-1:0]   fifo_level;
   logic [prach_pkg::n_carriers-1:0]                          fifo_ovfl;
   logic [prach_pkg::n_carriers-1:0]                          fifo_rd;     // pops from the packer

   // both config bits must be set for a carrier to take samples
   assign carrier_en = prach_en_cfg & ul_stream_en;

   for (genvar c = 0; c < prach_pkg::n_carriers; c++) begin : g_car

      prach_gain_stage u_gain (
         .clk_1x       (clk_1x),
         .resetn_1x    (resetn_1x),
         .clk_x1en     (clk_x1en[c]),
         .sample_valid (prach_in_valid[c]),
         .carrier_en   (carrier_en[c]),
         .sample_in    (prach_in[c]),
         .gain_cfg     (gain_cfg[c]),
         .wr           (fifo_wr[c]),       // no back-pressure toward the gain stage
         .sample_out   (fifo_din[c])
      );

      prach_sample_fifo u_fifo (
         .clk_1x       (clk_1x),
         .resetn_1x    (resetn_1x),
         .wr           (fifo_wr[c]),
         .rd           (fifo_rd[c]),
         .din          (fifo_din[c]),
         .dout         (fifo_head[c]),
         .empty        (),                 // packer works from the level
         .level        (fifo_level[c]),
         .ovfl         (fifo_ovfl[c])
      );

   end : g_car

   // one packer drains all carriers onto the oran stream
   prach_oran_packer u_packer (
      .clk_1x     (clk_1x),
      .resetn_1x  (resetn_1x),
      .level      (fifo_level),
      .head       (fifo_head),
      .rd         (fifo_rd),
      .ovfl       (fifo_ovfl),
      .swap_iq    (swap_iq),
      .clear      (clear),
      .oran_out   (oran_out),
      .oran_valid (oran_valid),
      .oran_ready (oran_ready),
      .err        (err)
   );

endmodule

/* src/prach_oran_packer.sv */
`timescale 1ns/1ps

module prach_oran_packer (
   input  logic                                                    clk_1x,
   input  logic                                                    resetn_1x,
   input  logic [prach_pkg::n_carriers-1:0][prach_pkg::lvl_bw-1:0] level,
   input  prach_pkg::prach_sample_t [prach_pkg::n_carriers-1:0]    head,
   output logic [prach_pkg::n_carriers-1:0]                        rd,
   input  logic [prach_pkg::n_carriers-1:0]                        ovfl,
   input  logic                                                    swap_iq,
   input  logic                                                    clear,
   output prach_pkg::prach_oran_t                                  oran_out,
   output logic                                                    oran_valid,
   input  logic                                                    oran_ready,
   output prach_pkg::prach_err_t                                   err
);

   logic [prach_pkg::car_bw-1:0]   rr_ptr;     // first carrier looked at when idle
   logic [prach_pkg::car_bw-1:0]   cur;        // carrier of the packet in flight
   logic [prach_pkg::car_bw-1:0]   idx;        // search walker
   logic [prach_pkg::car_bw-1:0]   sel;        // winner of the search
   logic                           found;
   logic [prach_pkg::beat_bw-1:0]  beat;       // beat number inside the packet
   logic                           swap_q;     // swap setting frozen per packet
   logic                           xfer;
   logic [prach_pkg::cnt_bw-1:0]   vld_cnt;
   logic [prach_pkg::cnt_bw-1:0]   ovfl_cnt;
   prach_pkg::prach_sample_t       cur_smp;

   assign xfer = oran_valid & oran_ready;

   // round robin search from rr_ptr for a carrier holding a whole packet
   always_comb begin
      found = 1'b0;
      sel   = rr_ptr;
      idx   = rr_ptr;
      for (int k = 0; k < prach_pkg::n_carriers; k++) begin
         if (!found && (level[idx] >= prach_pkg::pkt_lvl)) begin
            found = 1'b1;
            sel   = idx;
         end
         idx = (idx == prach_pkg::last_car) ? '0 : idx + 1'b1;   // wrap to carrier 0
      end
   end

   // packet control, idle for one cycle between packets so levels are fresh
   always_ff @(posedge clk_1x) begin
      if (!resetn_1x) begin
         oran_valid <= 1'b0;
         rr_ptr     <= '0;          // carrier 0 goes first after reset
         cur        <= '0;
         beat       <= '0;
         swap_q     <= 1'b0;
      end else if (!oran_valid) begin
         if (found) begin
            oran_valid <= 1'b1;
            cur        <= sel;
            beat       <= '0;
            swap_q     <= swap_iq;
         end
      end else if (oran_ready) begin
         beat <= beat + 1'b1;
         if (beat == prach_pkg::last_beat) begin
            oran_valid <= 1'b0;    // packet done, next search starts after cur
            rr_ptr     <= (cur == prach_pkg::last_car) ? '0 : cur + 1'b1;
         end
      end
   end

   // pop the head of the carrier in flight on each transfer
   always_comb begin
      rd      = '0;
      rd[cur] = xfer;
   end

   // beat comes straight off the fifo head, which only moves on a pop
   // so the word holds steady while stalled
   assign cur_smp = head[cur];

   always_comb begin
      if (swap_q)
         oran_out.tdata = {cur_smp.iq.i, cur_smp.iq.q};   // q into the low half
      else
         oran_out.tdata = cur_smp.iq;
      oran_out.tuser = {cur, cur_smp.usr_id};
      oran_out.tlast = (beat == prach_pkg::last_beat);
   end

   // error counters, saturating, clear has priority
   always_ff @(posedge clk_1x) begin
      if (!resetn_1x) begin
         vld_cnt  <= '0;
         ovfl_cnt <= '0;
      end else if (clear) begin
         vld_cnt  <= '0;
         ovfl_cnt <= '0;
      end else begin
         if (oran_valid && !oran_ready && (vld_cnt != '1))
            vld_cnt <= vld_cnt + 1'b1;      // one per stalled cycle
         if ((|ovfl) && (ovfl_cnt != '1))
            ovfl_cnt <= ovfl_cnt + 1'b1;    // carriers ored, one count per cycle
      end
   end

   assign err = '{vld_wo_rdy: vld_cnt, fifo_ovfl: ovfl_cnt};

endmodule

/* src/prach_sample_fifo.sv */
`timescale 1ns/1ps

module prach_sample_fifo (
   input  logic                             clk_1x,
   input  logic                             resetn_1x,
   input  logic                             wr,
   input  logic                             rd,
   input  prach_pkg::prach_sample_t         din,
   output prach_pkg::prach_sample_t         dout,    // head entry, valid while not empty
   output logic                             empty,
   output logic [prach_pkg::lvl_bw-1:0]     level,
   output logic                             ovfl     // write dropped on a full fifo
);

   prach_pkg::prach_sample_t              mem [prach_pkg::fifo_depth];
   logic [prach_pkg::fifo_aw-1:0]         wp;      // next slot to write
   logic [prach_pkg::fifo_aw-1:0]         rp;      // head slot
   logic                                  full;
   logic                                  do_wr;
   logic                                  do_rd;

   assign full  = (level == prach_pkg::full_lvl);
   assign empty = (level == '0);
   assign do_wr = wr & ~full;    // full wins even with a read in the same cycle
   assign do_rd = rd & ~empty;
   assign dout  = mem[rp];

   always_ff @(posedge clk_1x) begin
      if (do_wr) begin
         mem[wp] <= din;
      end
   end

   // pointers wrap on their own since depth is a power of two
   always_ff @(posedge clk_1x) begin
      if (!resetn_1x) begin
         wp    <= '0;
         rp    <= '0;
         level <= '0;
         ovfl  <= 1'b0;
      end else begin
         if (do_wr)
            wp <= wp + 1'b1;
         if (do_rd)
            rp <= rp + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;    // both or neither keeps the level
         endcase
         ovfl <= wr & full;             // one pulse per lost sample
      end
   end

endmodule

/* src/prach_gain_stage.sv */
`timescale 1ns/1ps

module prach_gain_stage (
   input  logic                         clk_1x,
   input  logic                         resetn_1x,
   input  logic                         clk_x1en,     // per-carrier sample strobe qualifier
   input  logic                         sample_valid,
   input  logic                         carrier_en,   // prach_en_cfg and ul_stream_en
   input  prach_pkg::prach_sample_t     sample_in,
   input  prach_pkg::prach_gain_cfg_t   gain_cfg,
   output logic                         wr,           // one cycle per sample into the fifo
   output prach_pkg::prach_sample_t     sample_out
);

   logic                      acc;      // input accepted this cycle
   logic                      s1_vld;   // stage 1 holds a sample
   prach_pkg::prach_sample_t  s1_smp;

   // multiply by fraction, arithmetic shift, optional negate, clamp to 16 bits
   function automatic logic signed [prach_pkg::precision-1:0] apply_gain(
      input logic signed [prach_pkg::precision-1:0] x,
      input prach_pkg::prach_gain_cfg_t             cfg
   );
      logic signed [prach_pkg::prod_bw-1:0] prod;
      logic signed [prach_pkg::prod_bw-1:0] shf;
      logic [4:0]                           sh;
      begin
         prod = x * $signed({1'b0, cfg.fraction});   // fraction kept positive
         sh   = 5'd16 - {1'b0, cfg.scaler};           // scaler 1..15 gives shift 15..1
         shf  = prod >>> sh;
         if (cfg.sign)
            shf = -shf;                               // headroom bit keeps this exact
         if (shf > prach_pkg::sat_hi)
            apply_gain = prach_pkg::sat_hi;
         else if (shf < prach_pkg::sat_lo)
            apply_gain = prach_pkg::sat_lo;
         else
            apply_gain = shf[prach_pkg::precision-1:0];
      end
   endfunction

   // a sample counts only with every qualifier high
   assign acc = clk_x1en & sample_valid & carrier_en;

   // stage 1, input register
   always_ff @(posedge clk_1x) begin
      if (!resetn_1x) begin
         s1_vld <= 1'b0;
      end else begin
         s1_vld <= acc;   // gated samples simply vanish
      end
   end

   always_ff @(posedge clk_1x) begin
      if (acc) begin
         s1_smp <= sample_in;   // payload only moves with a valid sample
      end
   end

   // stage 2, gain and saturate into the write register
   always_ff @(posedge clk_1x) begin
      if (!resetn_1x) begin
         wr <= 1'b0;
      end else begin
         wr <= s1_vld;
      end
   end

   always_ff @(posedge clk_1x) begin
      if (s1_vld) begin
         sample_out.iq.i   <= apply_gain(s1_smp.iq.i, gain_cfg);
         sample_out.iq.q   <= apply_gain(s1_smp.iq.q, gain_cfg);   // same rule on q
         sample_out.usr_id <= s1_smp.usr_id;                        // user id rides along
      end
   end

   // stage 1 and stage 2 each hold their own sample, so back to back
   // input strobes pass through at full rate

endmodule

/* src/prach_pkg.sv */
package prach_pkg;

   localparam int n_carriers = 2;    // carriers served round robin
   localparam int precision  = 16;   // bits per I or Q
   localparam int usr_id_bw  = 2;
   localparam int fifo_depth = 16;   // entries per carrier, power of two
   localparam int pkt_len    = 4;    // beats per oran packet
   localparam int cnt_bw     = 8;    // error counter width

   // derived widths
   localparam int car_bw  = (n_carriers > 1) ? $clog2(n_carriers) : 1;
   localparam int fifo_aw = $clog2(fifo_depth);
   localparam int lvl_bw  = fifo_aw + 1;                  // level spans 0..fifo_depth
   localparam int beat_bw = (pkt_len > 1) ? $clog2(pkt_len) : 1;
   localparam int prod_bw = 2*precision + 2;              // product plus room to negate

   // sized constants so compares stay width clean
   localparam logic [car_bw-1:0]  last_car  = car_bw'(n_carriers - 1);
   localparam logic [lvl_bw-1:0]  full_lvl  = lvl_bw'(fifo_depth);
   localparam logic [lvl_bw-1:0]  pkt_lvl   = lvl_bw'(pkt_len);
   localparam logic [beat_bw-1:0] last_beat = beat_bw'(pkt_len - 1);
   localparam logic signed [precision-1:0] sat_hi = {1'b0, {(precision-1){1'b1}}};
   localparam logic signed [precision-1:0] sat_lo = {1'b1, {(precision-1){1'b0}}};

   typedef struct packed {
      logic signed [precision-1:0] q;   // upper half of the iq word
      logic signed [precision-1:0] i;   // lower half
   } prach_iq_t;

   typedef struct packed {
      prach_iq_t             iq;
      logic [usr_id_bw-1:0]  usr_id;
   } prach_sample_t;                    // fifo payload, 34 bits

   typedef struct packed {
      logic        sign;                // negate after shift
      logic [3:0]  scaler;              // shift is 16 minus this
      logic [15:0] fraction;            // unsigned, 32768 is one half
   } prach_gain_cfg_t;

   typedef struct packed {
      logic [2*precision-1:0]        tdata;
      logic [car_bw+usr_id_bw-1:0]   tuser;   // carrier index above user id
      logic                          tlast;
   } prach_oran_t;

   typedef struct packed {
      logic [cnt_bw-1:0] vld_wo_rdy;
      logic [cnt_bw-1:0] fifo_ovfl;
   } prach_err_t;

endpackage
